//--- axi_pkg.sv
package axi_pkg;

    localparam int axi_addr_bits = 32;
    localparam int axi_data_bits = 32;
    localparam int axi_id_bits = 4;
    localparam int axi_len_bits = 4; // beats = len + 1.

    localparam logic [1:0] axi_resp_okay = 2'b00;
    localparam logic [1:0] axi_resp_decerr = 2'b11;

    // address map.
    localparam logic [axi_addr_bits-1:0] sram_base = 32'h0000_0000;
    localparam logic [axi_addr_bits-1:0] sram_bytes = 32'h0000_1000;

    // true for addresses served by the sram.
    function automatic logic in_sram_window(input logic [axi_addr_bits-1:0] addr);
        logic [axi_addr_bits-1:0] offset;
        offset = addr - sram_base;
        return offset < sram_bytes;
    endfunction

endpackage

//--- axi_read_router.sv
`timescale 1ns/10ps

module axi_read_router import axi_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axi_addr_bits-1:0] araddr,
    input  logic [axi_id_bits-1:0]   arid,
    input  logic [axi_len_bits-1:0]  arlen,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axi_data_bits-1:0] rdata,
    output logic [axi_id_bits-1:0]   rid,
    output logic [1:0]               rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [axi_addr_bits-1:0] sram_araddr,
    output logic [axi_id_bits-1:0]   sram_arid,
    output logic [axi_len_bits-1:0]  sram_arlen,
    output logic                     sram_arvalid,
    input  logic                     sram_arready,
    input  logic [axi_data_bits-1:0] sram_rdata,
    input  logic [axi_id_bits-1:0]   sram_rid,
    input  logic [1:0]               sram_rresp,
    input  logic                     sram_rlast,
    input  logic                     sram_rvalid,
    output logic                     sram_rready,
    output logic [axi_addr_bits-1:0] dflt_araddr,
    output logic [axi_id_bits-1:0]   dflt_arid,
    output logic [axi_len_bits-1:0]  dflt_arlen,
    output logic                     dflt_arvalid,
    input  logic                     dflt_arready,
    input  logic [axi_data_bits-1:0] dflt_rdata,
    input  logic [axi_id_bits-1:0]   dflt_rid,
    input  logic [1:0]               dflt_rresp,
    input  logic                     dflt_rlast,
    input  logic                     dflt_rvalid,
    output logic                     dflt_rready
);

    logic busy;
    logic sel_sram;
    logic dec_sram;

    assign dec_sram = in_sram_window(araddr);

    assign sram_araddr = araddr;
    assign sram_arid = arid;
    assign sram_arlen = arlen;
    assign dflt_araddr = araddr;
    assign dflt_arid = arid;
    assign dflt_arlen = arlen;

    // one burst open at a time.
    assign sram_arvalid = arvalid & ~busy & dec_sram;
    assign dflt_arvalid = arvalid & ~busy & ~dec_sram;
    assign arready = ~busy & (dec_sram ? sram_arready : dflt_arready);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            sel_sram <= 1'b0;
        end else if (arvalid && arready) begin
            busy <= 1'b1;
            sel_sram <= dec_sram;
        end else if (rvalid && rready && rlast) begin
            busy <= 1'b0;
        end
    end

    assign rvalid = busy & (sel_sram ? sram_rvalid : dflt_rvalid);
    assign rdata = sel_sram ? sram_rdata : dflt_rdata;
    assign rid = sel_sram ? sram_rid : dflt_rid;
    assign rresp = sel_sram ? sram_rresp : dflt_rresp;
    assign rlast = sel_sram ? sram_rlast : dflt_rlast;
    assign sram_rready = rready & busy & sel_sram;
    assign dflt_rready = rready & busy & ~sel_sram;

    // a target only answers the burst it was given.
    a_sram_rvalid_sel: assert property (@(posedge clk) disable iff (!rst)
        $rose(sram_rvalid) |-> busy && sel_sram);
    a_dflt_rvalid_sel: assert property (@(posedge clk) disable iff (!rst)
        $rose(dflt_rvalid) |-> busy && !sel_sram);

endmodule

//--- axi_write_router.sv
`timescale 1ns/10ps

module axi_write_router import axi_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axi_addr_bits-1:0] awaddr,
    input  logic [axi_id_bits-1:0]   awid,
    input  logic [axi_len_bits-1:0]  awlen,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axi_data_bits-1:0] wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [axi_id_bits-1:0]   bid,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [axi_addr_bits-1:0] sram_awaddr,
    output logic [axi_id_bits-1:0]   sram_awid,
    output logic [axi_len_bits-1:0]  sram_awlen,
    output logic                     sram_awvalid,
    input  logic                     sram_awready,
    output logic [axi_data_bits-1:0] sram_wdata,
    output logic                     sram_wlast,
    output logic                     sram_wvalid,
    input  logic                     sram_wready,
    input  logic [axi_id_bits-1:0]   sram_bid,
    input  logic [1:0]               sram_bresp,
    input  logic                     sram_bvalid,
    output logic                     sram_bready,
    output logic [axi_addr_bits-1:0] dflt_awaddr,
    output logic [axi_id_bits-1:0]   dflt_awid,
    output logic [axi_len_bits-1:0]  dflt_awlen,
    output logic                     dflt_awvalid,
    input  logic                     dflt_awready,
    output logic [axi_data_bits-1:0] dflt_wdata,
    output logic                     dflt_wlast,
    output logic                     dflt_wvalid,
    input  logic                     dflt_wready,
    input  logic [axi_id_bits-1:0]   dflt_bid,
    input  logic [1:0]               dflt_bresp,
    input  logic                     dflt_bvalid,
    output logic                     dflt_bready
);

    logic busy;
    logic sel_sram;
    logic dec_sram;

    assign dec_sram = in_sram_window(awaddr);

    assign sram_awaddr = awaddr;
    assign sram_awid = awid;
    assign sram_awlen = awlen;
    assign dflt_awaddr = awaddr;
    assign dflt_awid = awid;
    assign dflt_awlen = awlen;

    assign sram_awvalid = awvalid & ~busy & dec_sram;
    assign dflt_awvalid = awvalid & ~busy & ~dec_sram;
    assign awready = ~busy & (dec_sram ? sram_awready : dflt_awready);

    // open from the aw transfer until the b transfer.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            sel_sram <= 1'b0;
        end else if (awvalid && awready) begin
            busy <= 1'b1;
            sel_sram <= dec_sram;
        end else if (bvalid && bready) begin
            busy <= 1'b0;
        end
    end

    // w follows the registered target.
    assign sram_wdata = wdata;
    assign sram_wlast = wlast;
    assign dflt_wdata = wdata;
    assign dflt_wlast = wlast;
    assign sram_wvalid = wvalid & busy & sel_sram;
    assign dflt_wvalid = wvalid & busy & ~sel_sram;
    assign wready = busy & (sel_sram ? sram_wready : dflt_wready);

    assign bvalid = busy & (sel_sram ? sram_bvalid : dflt_bvalid);
    assign bid = sel_sram ? sram_bid : dflt_bid;
    assign bresp = sel_sram ? sram_bresp : dflt_bresp;
    assign sram_bready = bready & busy & sel_sram;
    assign dflt_bready = bready & busy & ~sel_sram;

    // w only offered once its aw has been taken.
    a_w_needs_aw: assert property (@(posedge clk) disable iff (!rst)
        wvalid |-> busy);

endmodule

//--- axi_default_slave.sv
`timescale 1ns/10ps

module axi_default_slave import axi_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axi_addr_bits-1:0] araddr,
    input  logic [axi_id_bits-1:0]   arid,
    input  logic [axi_len_bits-1:0]  arlen,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axi_data_bits-1:0] rdata,
    output logic [axi_id_bits-1:0]   rid,
    output logic [1:0]               rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [axi_addr_bits-1:0] awaddr,
    input  logic [axi_id_bits-1:0]   awid,
    input  logic [axi_len_bits-1:0]  awlen,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axi_data_bits-1:0] wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [axi_id_bits-1:0]   bid,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready
);

    typedef enum logic [1:0] {st_addr, st_read, st_write, st_resp} state_t;

    state_t state;
    state_t state_next;
    logic [axi_len_bits-1:0] beats_left;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) state <= st_addr;
        else state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            st_addr: begin
                if (arvalid && arready) state_next = st_read; // reads first.
                else if (awvalid && awready) state_next = st_write;
            end
            st_read: if (rvalid && rready && rlast) state_next = st_addr;
            st_write: if (wvalid && wready && wlast) state_next = st_resp;
            st_resp: if (bvalid && bready) state_next = st_addr;
            default: state_next = st_addr;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beats_left <= '0;
            rlast <= 1'b0;
        end else if (arvalid && arready) begin
            beats_left <= arlen;
            rlast <= (arlen == '0);
        end else if (rvalid && rready && !rlast) begin
            beats_left <= beats_left - 1'b1;
            rlast <= (beats_left == axi_len_bits'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) rid <= arid;
        if (awvalid && awready) bid <= awid;
    end

    assign arready = (state == st_addr);
    assign awready = (state == st_addr) & awvalid & ~arvalid;
    assign wready = (state == st_write) & wvalid;
    assign rvalid = (state == st_read);
    assign bvalid = (state == st_resp);
    assign rdata = '0;
    assign rresp = axi_resp_decerr;
    assign bresp = axi_resp_decerr;

    a_rlast_count: assert property (@(posedge clk) disable iff (!rst)
        rvalid |-> (rlast == (beats_left == '0)));

    // requests held steady by the master side while stalled.
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> $stable({araddr, arid, arlen}));
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> $stable({awaddr, awid, awlen}));
    a_w_hold: assert property (@(posedge clk) disable iff (!rst)
        wvalid && !wready |=> $stable({wdata, wlast}));

endmodule

//--- axi_sram_slave.sv
`timescale 1ns/10ps

module axi_sram_slave import axi_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axi_addr_bits-1:0] araddr,
    input  logic [axi_id_bits-1:0]   arid,
    input  logic [axi_len_bits-1:0]  arlen,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axi_data_bits-1:0] rdata,
    output logic [axi_id_bits-1:0]   rid,
    output logic [1:0]               rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [axi_addr_bits-1:0] awaddr,
    input  logic [axi_id_bits-1:0]   awid,
    input  logic [axi_len_bits-1:0]  awlen,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axi_data_bits-1:0] wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [axi_id_bits-1:0]   bid,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready
);

    localparam int idx_bits = $clog2(mem_words);

    typedef enum logic [1:0] {st_addr, st_read, st_write, st_resp} state_t;

    state_t state;
    state_t state_next;
    logic [axi_len_bits-1:0] beats_left;
    logic [axi_data_bits-1:0] mem [mem_words];
    logic [idx_bits-1:0] ptr; // current word.

    function automatic logic [idx_bits-1:0] word_of(input logic [axi_addr_bits-1:0] addr);
        logic [axi_addr_bits-1:0] offset;
        offset = addr - sram_base;
        return idx_bits'((offset >> 2) % mem_words);
    endfunction

    // incr burst, wrapping at the top of the array.
    function automatic logic [idx_bits-1:0] next_word(input logic [idx_bits-1:0] w);
        return (w == idx_bits'(mem_words - 1)) ? '0 : w + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) state <= st_addr;
        else state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            st_addr: begin
                if (arvalid && arready) state_next = st_read;
                else if (awvalid && awready) state_next = st_write;
            end
            st_read: if (rvalid && rready && rlast) state_next = st_addr;
            st_write: if (wvalid && wready && wlast) state_next = st_resp;
            st_resp: if (bvalid && bready) state_next = st_addr;
            default: state_next = st_addr;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beats_left <= '0;
            rlast <= 1'b0;
        end else if (arvalid && arready) begin
            beats_left <= arlen;
            rlast <= (arlen == '0);
        end else if (rvalid && rready && !rlast) begin
            beats_left <= beats_left - 1'b1;
            rlast <= (beats_left == axi_len_bits'(1));
        end
    end

    // registered read, next word fetched on each beat transfer.
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= mem[word_of(araddr)];
            ptr <= next_word(word_of(araddr));
            rid <= arid;
        end else if (rvalid && rready && !rlast) begin
            rdata <= mem[ptr];
            ptr <= next_word(ptr);
        end else if (awvalid && awready) begin
            ptr <= word_of(awaddr);
            bid <= awid;
        end else if (wvalid && wready) begin
            mem[ptr] <= wdata; // full word, strobes ignored.
            ptr <= next_word(ptr);
        end
    end

    assign arready = (state == st_addr);
    assign awready = (state == st_addr) & awvalid & ~arvalid;
    assign wready = (state == st_write) & wvalid;
    assign rvalid = (state == st_read);
    assign bvalid = (state == st_resp);
    assign rresp = axi_resp_okay;
    assign bresp = axi_resp_okay;

    a_one_addr_grant: assert property (@(posedge clk) disable iff (!rst)
        !(arvalid && arready && awvalid && awready));

    // burst length on aw agrees with the beats that arrive.
    a_wlast_len: assert property (@(posedge clk) disable iff (!rst)
        awvalid && awready && awlen == '0 |=> !wvalid || wlast);

endmodule

//--- axi_mem_subsys.sv
`timescale 1ns/10ps

module axi_mem_subsys import axi_pkg::*; #(
    parameter int mem_words = sram_bytes / 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axi_addr_bits-1:0] araddr,
    input  logic [axi_id_bits-1:0]   arid,
    input  logic [axi_len_bits-1:0]  arlen,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axi_data_bits-1:0] rdata,
    output logic [axi_id_bits-1:0]   rid,
    output logic [1:0]               rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [axi_addr_bits-1:0] awaddr,
    input  logic [axi_id_bits-1:0]   awid,
    input  logic [axi_len_bits-1:0]  awlen,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axi_data_bits-1:0] wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [axi_id_bits-1:0]   bid,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready
);

    logic [axi_addr_bits-1:0] sram_araddr, sram_awaddr, dflt_araddr, dflt_awaddr;
    logic [axi_id_bits-1:0] sram_arid, sram_rid, sram_awid, sram_bid;
    logic [axi_id_bits-1:0] dflt_arid, dflt_rid, dflt_awid, dflt_bid;
    logic [axi_len_bits-1:0] sram_arlen, sram_awlen, dflt_arlen, dflt_awlen;
    logic [axi_data_bits-1:0] sram_rdata, sram_wdata, dflt_rdata, dflt_wdata;
    logic [1:0] sram_rresp, sram_bresp, dflt_rresp, dflt_bresp;
    logic sram_arvalid, sram_arready, sram_rlast, sram_rvalid, sram_rready;
    logic sram_awvalid, sram_awready, sram_wlast, sram_wvalid, sram_wready;
    logic sram_bvalid, sram_bready;
    logic dflt_arvalid, dflt_arready, dflt_rlast, dflt_rvalid, dflt_rready;
    logic dflt_awvalid, dflt_awready, dflt_wlast, dflt_wvalid, dflt_wready;
    logic dflt_bvalid, dflt_bready;

    // router ports share names with the nets above.
    axi_read_router rd_router_i (.*);
    axi_write_router wr_router_i (.*);

    axi_sram_slave #(.mem_words(mem_words)) sram_i (
        .clk(clk), .rst(rst),
        .araddr(sram_araddr), .arid(sram_arid), .arlen(sram_arlen),
        .arvalid(sram_arvalid), .arready(sram_arready),
        .rdata(sram_rdata), .rid(sram_rid), .rresp(sram_rresp), .rlast(sram_rlast),
        .rvalid(sram_rvalid), .rready(sram_rready),
        .awaddr(sram_awaddr), .awid(sram_awid), .awlen(sram_awlen),
        .awvalid(sram_awvalid), .awready(sram_awready),
        .wdata(sram_wdata), .wlast(sram_wlast), .wvalid(sram_wvalid), .wready(sram_wready),
        .bid(sram_bid), .bresp(sram_bresp), .bvalid(sram_bvalid), .bready(sram_bready)
    );

    axi_default_slave dflt_i (
        .clk(clk), .rst(rst),
        .araddr(dflt_araddr), .arid(dflt_arid), .arlen(dflt_arlen),
        .arvalid(dflt_arvalid), .arready(dflt_arready),
        .rdata(dflt_rdata), .rid(dflt_rid), .rresp(dflt_rresp), .rlast(dflt_rlast),
        .rvalid(dflt_rvalid), .rready(dflt_rready),
        .awaddr(dflt_awaddr), .awid(dflt_awid), .awlen(dflt_awlen),
        .awvalid(dflt_awvalid), .awready(dflt_awready),
        .wdata(dflt_wdata), .wlast(dflt_wlast), .wvalid(dflt_wvalid), .wready(dflt_wready),
        .bid(dflt_bid), .bresp(dflt_bresp), .bvalid(dflt_bvalid), .bready(dflt_bready)
    );

endmodule

//--- axi_checker.sv
`timescale 1ns/10ps

module axi_checker import axi_pkg::*; #(
    parameter int mem_words = 1024
) (
    input logic                     clk,
    input logic                     rst,
    input logic [axi_addr_bits-1:0] araddr,
    input logic [axi_addr_bits-1:0] awaddr,
    input logic [axi_id_bits-1:0]   arid,
    input logic [axi_id_bits-1:0]   rid,
    input logic [axi_id_bits-1:0]   awid,
    input logic [axi_id_bits-1:0]   bid,
    input logic [axi_len_bits-1:0]  arlen,
    input logic [axi_len_bits-1:0]  awlen,
    input logic [axi_data_bits-1:0] rdata,
    input logic [axi_data_bits-1:0] wdata,
    input logic [1:0]               rresp,
    input logic [1:0]               bresp,
    input logic arvalid, arready, rvalid, rready, rlast,
    input logic awvalid, awready, wvalid, wready, wlast,
    input logic bvalid, bready
);

    logic [axi_data_bits-1:0] model [mem_words]; // expected sram contents.
    int errors = 0;
    logic rd_open = 1'b0;
    logic rd_sram;
    logic [axi_id_bits-1:0] rd_id;
    int rd_ptr;
    int rd_left; // beats still owed.
    logic wr_open = 1'b0;
    logic wr_done;
    logic wr_sram;
    logic [axi_id_bits-1:0] wr_id;
    int wr_ptr;
    int wr_left;
    logic r_stall;
    logic b_stall;
    logic [39:0] r_held;
    logic [6:0] b_held;

    function automatic logic maps_to_sram(input logic [31:0] addr);
        return (addr >= sram_base) && (addr < sram_base + sram_bytes);
    endfunction

    // word slot inside the sram, wrapping at its depth.
    function automatic int word_index(input logic [31:0] addr);
        return int'(((addr - sram_base) >> 2) % mem_words);
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] observed);
        if (observed !== expected) begin
            $display("Fail %0t: %s expected %h, observed %h", $time, name, expected, observed);
            errors++;
        end
    endtask

    task automatic fault(input string what);
        $display("%0t: %s", $time, what);
        errors++;
    endtask

    // sampled at the negedge, where every port is settled.
    always @(negedge clk) begin
        if (!rst) begin
            rd_open = 1'b0;
            wr_open = 1'b0;
            wr_done = 1'b0;
            r_stall = 1'b0;
            b_stall = 1'b0;
        end else begin
            if (r_stall) compare("R payload while stalled", 64'(r_held),
                                 64'({rvalid, rdata, rid, rresp, rlast}));
            if (b_stall) compare("B payload while stalled", 64'(b_held),
                                 64'({bvalid, bid, bresp}));
            r_stall = rvalid && !rready;
            b_stall = bvalid && !bready;
            r_held = {rvalid, rdata, rid, rresp, rlast};
            b_held = {bvalid, bid, bresp};
            if (rvalid && !rd_open) fault("R beat with no read open");
            if (bvalid && !wr_done) fault("B response before the last W beat");
            if (arvalid && arready) begin
                if (rd_open) fault("AR accepted while a read is open");
                rd_open = 1'b1;
                rd_sram = maps_to_sram(araddr);
                rd_ptr = word_index(araddr);
                rd_id = arid;
                rd_left = int'(arlen) + 1;
            end
            if (rvalid && rready && rd_open) begin
                compare("rid", 64'(rd_id), 64'(rid));
                compare("rresp", 64'(rd_sram ? axi_resp_okay : axi_resp_decerr), 64'(rresp));
                compare("rdata", rd_sram ? 64'(model[rd_ptr]) : 64'(0), 64'(rdata));
                compare("rlast", 64'(rd_left == 1), 64'(rlast));
                rd_ptr = (rd_ptr + 1) % mem_words;
                rd_left--;
                if (rlast || rd_left == 0) rd_open = 1'b0;
            end
            if (awvalid && awready) begin
                if (wr_open) fault("AW accepted while a write is open");
                wr_open = 1'b1;
                wr_done = 1'b0;
                wr_sram = maps_to_sram(awaddr);
                wr_ptr = word_index(awaddr);
                wr_id = awid;
                wr_left = int'(awlen) + 1;
            end
            if (wvalid && wready) begin
                if (!wr_open || wr_done) begin
                    fault("W beat accepted with no write open");
                end else begin
                    compare("wlast", 64'(wr_left == 1), 64'(wlast));
                    if (wr_sram) model[wr_ptr] = wdata; // unmapped writes leave it alone.
                    wr_ptr = (wr_ptr + 1) % mem_words;
                    wr_left--;
                    if (wr_left == 0) wr_done = 1'b1; // all beats of the burst taken.
                end
            end
            if (bvalid && bready && wr_done) begin
                compare("bid", 64'(wr_id), 64'(bid));
                compare("bresp", 64'(wr_sram ? axi_resp_okay : axi_resp_decerr), 64'(bresp));
                wr_open = 1'b0;
                wr_done = 1'b0;
            end
        end
    end

endmodule

//--- tb_axi_mem_subsys.sv
`timescale 1ns/10ps

module tb_axi_mem_subsys import axi_pkg::*; ();

    localparam int mem_words = sram_bytes / 4;
    localparam int timeout_cycles = 200;

    // handshakes that the drivers wait on.
    localparam int hs_ar = 0;
    localparam int hs_r_last = 1;
    localparam int hs_aw = 2;
    localparam int hs_w = 3;
    localparam int hs_b = 4;
    localparam int hs_idle = 5;

    logic clk = 1'b0;
    logic rst;
    logic [axi_addr_bits-1:0] araddr;
    logic [axi_id_bits-1:0] arid;
    logic [axi_len_bits-1:0] arlen;
    logic arvalid;
    logic arready;
    logic [axi_data_bits-1:0] rdata;
    logic [axi_id_bits-1:0] rid;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready = 1'b0;
    logic [axi_addr_bits-1:0] awaddr;
    logic [axi_id_bits-1:0] awid;
    logic [axi_len_bits-1:0] awlen;
    logic awvalid;
    logic awready;
    logic [axi_data_bits-1:0] wdata;
    logic wlast;
    logic wvalid;
    logic wready;
    logic [axi_id_bits-1:0] bid;
    logic [1:0] bresp;
    logic bvalid;
    logic bready = 1'b0;
    int seed = 61;
    int drive_errors = 0;

    axi_mem_subsys #(.mem_words(mem_words)) dut_i (.*);
    axi_checker #(.mem_words(mem_words)) checker_i (.*);

    always #20 clk = ~clk;

    // r and b ready about three cycles in four.
    always @(posedge clk) begin
        #1;
        rready = ($random(seed) & 3) != 0;
        bready = ($random(seed) & 3) != 0;
    end

    function automatic logic handshake_seen(input int which);
        case (which)
            hs_ar: return arvalid && arready;
            hs_r_last: return rvalid && rready && rlast;
            hs_aw: return awvalid && awready;
            hs_w: return wvalid && wready;
            hs_b: return bvalid && bready;
            hs_idle: return !checker_i.rd_open && !checker_i.wr_open;
            default: return 1'b0;
        endcase
    endfunction

    // looks at the negedge, returns just after the edge that made the transfer.
    task automatic await_transfer(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!handshake_seen(which) && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!handshake_seen(which)) begin
            $display("%0t: timed out waiting for %s", $time, what);
            drive_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic issue_read(input logic [31:0] addr, input int len, input logic [3:0] id);
        araddr = addr;
        arid = id;
        arlen = axi_len_bits'(len);
        arvalid = 1'b1;
        await_transfer(hs_ar, "arready");
        arvalid = 1'b0;
        await_transfer(hs_r_last, "the last read beat");
    endtask

    task automatic issue_write(
        input logic [31:0] addr,
        input int len,
        input logic [3:0] id,
        input logic [31:0] data_seed
    );
        awaddr = addr;
        awid = id;
        awlen = axi_len_bits'(len);
        awvalid = 1'b1;
        await_transfer(hs_aw, "awready");
        awvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            wdata = data_seed + 32'(i);
            wlast = (i == len);
            wvalid = 1'b1;
            await_transfer(hs_w, "wready");
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        await_transfer(hs_b, "the write response");
    endtask

    initial begin
        int fd;
        int code;
        int len;
        string line;
        logic [7:0] op;
        logic [31:0] addr;
        logic [31:0] data_seed;
        logic [3:0] id;
        rst = 1'b0;
        araddr = '0;
        arid = '0;
        arlen = '0;
        arvalid = 1'b0;
        awaddr = '0;
        awid = '0;
        awlen = '0;
        awvalid = 1'b0;
        wdata = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        fd = $fopen("axi_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open axi_patterns.txt");
            drive_errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %h %d %h %h", op, addr, len, id, data_seed);
            if (code != 5) begin
                $display("malformed pattern line: %s", line);
                drive_errors++;
            end else if (op == "R") begin
                issue_read(addr, len, id);
            end else if (op == "W") begin
                issue_write(addr, len, id, data_seed);
            end else begin
                $display("unknown operation in pattern line: %s", line);
                drive_errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        await_transfer(hs_idle, "the end of the patterns");
        repeat (4) @(posedge clk);
        $display("errors: %0d from checks, %0d from the drivers",
                 checker_i.errors, drive_errors);
        if (checker_i.errors == 0 && drive_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- axi_patterns.txt
# op addr len id seed: op is R or W, addr id and seed in hex, len in decimal
# len is beats minus one, write beat data is seed plus beat index
R 00002000 3 1 00000000
W 00000010 0 2 a5a50000
W 00000100 7 3 12340000
R 00000010 0 4 00000000
R 00000100 7 5 00000000
R 0000fff0 15 6 00000000
W 00001100 3 7 deadbe00
R 00000100 7 8 00000000
W 00000ff8 3 9 55550000
R 00000ff8 3 a 00000000
W 00000200 1 b 77770000
R 00003000 1 c 00000000
W 00001000 0 d 0badf00d
R 00000200 1 e 00000000
W 00000ffc 0 f 11110000
R 00000ff8 3 0 00000000
W 00008000 2 1 c0de0000
R 00000000 1 2 00000000

//--- sources.f
axi_pkg.sv
axi_read_router.sv
axi_write_router.sv
axi_default_slave.sv
axi_sram_slave.sv
axi_mem_subsys.sv
axi_checker.sv
tb_axi_mem_subsys.sv

//--- Makefile
TOP = tb_axi_mem_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
